/* tb.f */
rtl/fetch_pred_pkg.sv
rtl/branch_target_buffer.sv
rtl/return_addr_stack.sv
rtl/next_pc_arbiter.sv
rtl/fetch_predictor.sv
+incdir+bench
bench/fetch_predictor_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = fetch_predictor_tb
FILELIST = tb.f
PASS_MSG = PASS: all tests

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove the build directory"

$(SIM):
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/fetch_predictor_vectors.svh */
`ifndef FETCH_PREDICTOR_VECTORS_SVH
`define FETCH_PREDICTOR_VECTORS_SVH

// One row per clock cycle
// exp_pc is the fetch pc during that cycle, exp_src the rule picking the next pc
typedef struct packed {
  int      test;
  int      stall;
  int      redirect;
  int      redirect_target;
  int      upd;
  int      upd_pc;
  int      upd_target;
  int      upd_taken;
  int      upd_is_return;
  int      push;
  int      push_addr;
  int      pop;
  int      exp_pc;
  pc_src_e exp_src;
} vec_t;

localparam int NUM_VECTORS = 61;

// test stall redir redir_tgt upd upd_pc upd_tgt taken ret push push_addr pop exp_pc exp_src
localparam vec_t VECTORS [NUM_VECTORS] = '{
  '{1, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h0,    PC_SRC_SEQ},
  '{1, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h4,    PC_SRC_SEQ},
  '{1, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h8,    PC_SRC_SEQ},
  '{1, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'hc,    PC_SRC_SEQ},
  // Taken entry, not-taken entry, tag alias and overwrite
  '{2, 0, 0, 'h0,   1, 'h18,  'h100, 1, 0, 0, 'h0,    0, 'h10,   PC_SRC_SEQ},
  '{2, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h14,   PC_SRC_SEQ},
  '{2, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h18,   PC_SRC_BTB},
  '{2, 0, 0, 'h0,   1, 'h104, 'h200, 0, 0, 0, 'h0,    0, 'h100,  PC_SRC_SEQ},
  '{2, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h104,  PC_SRC_SEQ},
  '{2, 0, 1, 'h58,  0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h108,  PC_SRC_REDIRECT},
  '{2, 0, 0, 'h0,   1, 'h58,  'h300, 1, 0, 0, 'h0,    0, 'h58,   PC_SRC_SEQ},
  '{2, 0, 1, 'h18,  0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h5c,   PC_SRC_REDIRECT},
  '{2, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h18,   PC_SRC_SEQ},
  '{2, 0, 1, 'h58,  0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h1c,   PC_SRC_REDIRECT},
  '{2, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h58,   PC_SRC_BTB},
  // Return entry at 0x420 with nested calls
  '{3, 0, 0, 'h0,   1, 'h420, 'h500, 1, 1, 1, 'h1000, 0, 'h300,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h2000, 0, 'h304,  PC_SRC_SEQ},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h308,  PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h420,  PC_SRC_RAS},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h2000, PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h420,  PC_SRC_RAS},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h1000, PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h420,  PC_SRC_BTB},
  // Push then push with pop replaces the top
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h3000, 0, 'h500,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h3100, 1, 'h504,  PC_SRC_SEQ},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h508,  PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h420,  PC_SRC_RAS},
  // Nothing is left under the replaced top
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h3100, PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h420,  PC_SRC_BTB},
  // Nine pushes into eight slots
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4100, 0, 'h500,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4200, 0, 'h504,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4300, 0, 'h508,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4400, 0, 'h50c,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4500, 0, 'h510,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4600, 0, 'h514,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4700, 0, 'h518,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4800, 0, 'h51c,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h4900, 0, 'h520,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h524,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h528,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h52c,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h530,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h534,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h538,  PC_SRC_SEQ},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h53c,  PC_SRC_SEQ},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h540,  PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h420,  PC_SRC_RAS},
  '{3, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h4200, PC_SRC_REDIRECT},
  '{3, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h420,  PC_SRC_BTB},
  // Redirect beats RAS, BTB and stall
  '{4, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 1, 'h6000, 0, 'h500,  PC_SRC_REDIRECT},
  '{4, 1, 1, 'h700, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h420,  PC_SRC_REDIRECT},
  '{4, 0, 1, 'h58,  0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h700,  PC_SRC_REDIRECT},
  '{4, 0, 1, 'h800, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h58,   PC_SRC_REDIRECT},
  // Updates during stall land anyway
  '{5, 1, 0, 'h0,   1, 'h808, 'h900, 1, 0, 0, 'h0,    0, 'h800,  PC_SRC_SEQ},
  '{5, 1, 0, 'h0,   0, 'h0,   'h0,   0, 0, 1, 'h7000, 0, 'h800,  PC_SRC_SEQ},
  '{5, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h800,  PC_SRC_SEQ},
  '{5, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h804,  PC_SRC_SEQ},
  '{5, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h808,  PC_SRC_BTB},
  '{5, 0, 1, 'h420, 0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h900,  PC_SRC_REDIRECT},
  '{5, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    1, 'h420,  PC_SRC_RAS},
  '{5, 0, 0, 'h0,   0, 'h0,   'h0,   0, 0, 0, 'h0,    0, 'h7000, PC_SRC_SEQ}
};

`endif

/* bench/fetch_predictor_tb.sv */
module fetch_predictor_tb
  import fetch_pred_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD   = 20;
  localparam int RESET_CYCLES  = 4;
  localparam int RESET_TIMEOUT = 20;
  localparam int RANDOM_CYCLES = 24;
  localparam int RANDOM_TEST   = 6;
  localparam int SIM_TIMEOUT   = 200000;

  `include "fetch_predictor_vectors.svh"

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic        redirect;
  logic [31:0] redirect_target;
  logic        btb_update;
  logic [31:0] btb_update_pc;
  logic [31:0] btb_update_target;
  logic        btb_update_taken;
  logic        btb_update_is_return;
  logic        ras_push;
  logic [31:0] ras_push_addr;
  logic        ras_pop;
  logic [31:0] pc;
  pc_src_e     pc_src;

  int          seed;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;

  fetch_predictor i_dut (
    .clk                  (clk),
    .rst_n                (rst_n),
    .stall                (stall),
    .redirect             (redirect),
    .redirect_target      (redirect_target),
    .btb_update           (btb_update),
    .btb_update_pc        (btb_update_pc),
    .btb_update_target    (btb_update_target),
    .btb_update_taken     (btb_update_taken),
    .btb_update_is_return (btb_update_is_return),
    .ras_push             (ras_push),
    .ras_push_addr        (ras_push_addr),
    .ras_pop              (ras_pop),
    .pc                   (pc),
    .pc_src               (pc_src)
  );

  always #(HALF_PERIOD) clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic apply_row(input vec_t v);
    stall                <= (v.stall != 0);
    redirect             <= (v.redirect != 0);
    redirect_target      <= v.redirect_target;
    btb_update           <= (v.upd != 0);
    btb_update_pc        <= v.upd_pc;
    btb_update_target    <= v.upd_target;
    btb_update_taken     <= (v.upd_taken != 0);
    btb_update_is_return <= (v.upd_is_return != 0);
    ras_push             <= (v.push != 0);
    ras_push_addr        <= v.push_addr;
    ras_pop              <= (v.pop != 0);
  endtask

  task automatic check_outputs(input logic [31:0] exp_pc, input pc_src_e exp_src);
    assert (pc === exp_pc) else begin
      $display("Fail at %0d ns: pc expected %h actual %h", $time, exp_pc, pc);
      test_errors++;
    end
    assert (pc_src === exp_src) else begin
      $display("Fail at %0d ns: pc_src expected %s actual %s", $time,
               exp_src.name(), pc_src.name());
      test_errors++;
    end
  endtask

  task automatic report_test(input int num);
    if (test_errors == 0) begin
      $display("test %0d passed", num);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released within %0d cycles", RESET_TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    int          cur_test;
    logic [31:0] exp_pc;
    logic        stall_bit;
    clk                  = 1'b0;
    rst_n                = 1'b0;
    // Stall during reset keeps pc at its reset value for the first row
    stall                = 1'b1;
    redirect             = 1'b0;
    redirect_target      = '0;
    btb_update           = 1'b0;
    btb_update_pc        = '0;
    btb_update_target    = '0;
    btb_update_taken     = 1'b0;
    btb_update_is_return = 1'b0;
    ras_push             = 1'b0;
    ras_push_addr        = '0;
    ras_pop              = 1'b0;
    seed                 = 26557;
    test_errors          = 0;
    total_errors         = 0;
    tests_passed         = 0;
    tests_failed         = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    wait_reset_release();

    cur_test = VECTORS[0].test;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (VECTORS[i].test != cur_test) begin
        report_test(cur_test);
        cur_test = VECTORS[i].test;
      end
      @(posedge clk);
      apply_row(VECTORS[i]);
      @(negedge clk);
      check_outputs(VECTORS[i].exp_pc, VECTORS[i].exp_src);
    end
    report_test(cur_test);

    // Random stall tail where pc holds or steps by one instruction
    exp_pc = VECTORS[NUM_VECTORS-1].exp_pc + 32'd4;
    for (int k = 0; k < RANDOM_CYCLES; k++) begin
      stall_bit = $random(seed) & 1;
      @(posedge clk);
      apply_row('{RANDOM_TEST, stall_bit, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, PC_SRC_SEQ});
      @(negedge clk);
      check_outputs(exp_pc, PC_SRC_SEQ);
      if (!stall_bit) begin
        exp_pc = exp_pc + 32'd4;
      end
    end
    report_test(RANDOM_TEST);

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Overall limit on the run
  initial begin
    #(SIM_TIMEOUT);
    $display("Simulation did not finish within %0d ns", SIM_TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* rtl/fetch_predictor.sv */
module fetch_predictor
  import fetch_pred_pkg::*;
#(
  parameter int                ADDR_W      = 32,
  parameter int                BTB_ENTRIES = 16,
  parameter int                RAS_DEPTH   = 8,
  parameter logic [ADDR_W-1:0] RESET_PC    = '0
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              stall,
  input  logic              redirect,
  input  logic [ADDR_W-1:0] redirect_target,

  // BTB training from branch resolution
  input  logic              btb_update,
  input  logic [ADDR_W-1:0] btb_update_pc,
  input  logic [ADDR_W-1:0] btb_update_target,
  input  logic              btb_update_taken,
  input  logic              btb_update_is_return,

  // Call and return tracking
  input  logic              ras_push,
  input  logic [ADDR_W-1:0] ras_push_addr,
  input  logic              ras_pop,

  output logic [ADDR_W-1:0] pc,
  output pc_src_e           pc_src
);

  logic              btb_hit;
  logic              btb_taken;
  logic              btb_is_return;
  logic [ADDR_W-1:0] btb_target;
  logic              ras_valid;
  logic [ADDR_W-1:0] ras_target;

  // BTB looks up the live fetch pc
  branch_target_buffer #(
    .ADDR_W      (ADDR_W),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_btb (
    .clk              (clk),
    .rst_n            (rst_n),
    .lookup_pc        (pc),
    .hit              (btb_hit),
    .taken            (btb_taken),
    .is_return        (btb_is_return),
    .target           (btb_target),
    .update_en        (btb_update),
    .update_pc        (btb_update_pc),
    .update_target    (btb_update_target),
    .update_taken     (btb_update_taken),
    .update_is_return (btb_update_is_return)
  );

  return_addr_stack #(
    .ADDR_W    (ADDR_W),
    .RAS_DEPTH (RAS_DEPTH)
  ) i_ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_en   (ras_push),
    .push_addr (ras_push_addr),
    .pop_en    (ras_pop),
    .valid     (ras_valid),
    .top_addr  (ras_target)
  );

  next_pc_arbiter #(
    .ADDR_W   (ADDR_W),
    .RESET_PC (RESET_PC)
  ) i_arbiter (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .btb_hit         (btb_hit),
    .btb_taken       (btb_taken),
    .btb_is_return   (btb_is_return),
    .btb_target      (btb_target),
    .ras_valid       (ras_valid),
    .ras_target      (ras_target),
    .pc              (pc),
    .pc_src          (pc_src)
  );

endmodule

/* rtl/next_pc_arbiter.sv */
module next_pc_arbiter
  import fetch_pred_pkg::*;
#(
  parameter int                ADDR_W   = 32,
  parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst_n,

  // Pipeline control
  input  logic              stall,
  input  logic              redirect,
  input  logic [ADDR_W-1:0] redirect_target,

  // BTB lookup result for the current pc
  input  logic              btb_hit,
  input  logic              btb_taken,
  input  logic              btb_is_return,
  input  logic [ADDR_W-1:0] btb_target,

  // RAS top of stack
  input  logic              ras_valid,
  input  logic [ADDR_W-1:0] ras_target,

  output logic [ADDR_W-1:0] pc,
  output pc_src_e           pc_src
);

  logic [ADDR_W-1:0] next_pc;
  logic [ADDR_W-1:0] seq_pc;
  logic              use_ras;
  logic              use_btb;
  logic              pc_load;

  // ----------------------------------------
  // Next PC selection
  // ----------------------------------------

  assign seq_pc  = pc + ADDR_W'(INSTR_BYTES);
  assign use_ras = btb_hit && btb_is_return && ras_valid;
  assign use_btb = btb_hit && btb_taken;

  // Redirect first, then return, then taken branch, then fall through
  always_comb begin
    if (redirect) begin
      next_pc = redirect_target;
      pc_src  = PC_SRC_REDIRECT;
    end else if (use_ras) begin
      next_pc = ras_target;
      pc_src  = PC_SRC_RAS;
    end else if (use_btb) begin
      next_pc = btb_target;
      pc_src  = PC_SRC_BTB;
    end else begin
      next_pc = seq_pc;
      pc_src  = PC_SRC_SEQ;
    end
  end

  // ----------------------------------------
  // Fetch PC register
  // ----------------------------------------

  // A redirect must land even while fetch is stalled
  assign pc_load = redirect || !stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (pc_load) begin
      pc <= next_pc;
    end
  end

  redirect_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect |-> (redirect_target[ALIGN_BITS-1:0] == '0)
  ) else $error("Redirect to unaligned target %h", redirect_target);

  // Holds only if every source, BTB and RAS included, feeds aligned targets
  pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[ALIGN_BITS-1:0] == '0
  ) else $error("Fetch pc %h is not aligned", pc);

endmodule

/* rtl/return_addr_stack.sv */
module return_addr_stack #(
  parameter int ADDR_W    = 32,
  parameter int RAS_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,

  // Call and return events
  input  logic              push_en,
  input  logic [ADDR_W-1:0] push_addr,
  input  logic              pop_en,

  // Top of stack is valid while not empty
  output logic              valid,
  output logic [ADDR_W-1:0] top_addr
);

  localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(RAS_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(RAS_DEPTH);

  logic [ADDR_W-1:0] slots [RAS_DEPTH];
  logic [PTR_W-1:0]  top_ptr;
  logic [PTR_W-1:0]  next_ptr;
  logic [PTR_W-1:0]  prev_ptr;
  logic [PTR_W-1:0]  wr_ptr;
  logic [CNT_W-1:0]  count;
  logic              empty;
  logic              full;
  logic              replace;

  // ----------------------------------------
  // Pointer arithmetic
  // ----------------------------------------

  // Circular wrap since depth need not be a power of two
  assign next_ptr = (top_ptr == LAST_SLOT) ? '0 : top_ptr + PTR_W'(1);
  assign prev_ptr = (top_ptr == '0) ? LAST_SLOT : top_ptr - PTR_W'(1);

  assign empty = (count == '0);
  assign full  = (count == FULL_COUNT);

  // Push with pop on a non-empty stack swaps the top in place
  assign replace = push_en && pop_en && !empty;
  assign wr_ptr  = replace ? top_ptr : next_ptr;

  // ----------------------------------------
  // Control state
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push_en && !replace) begin
      // Full stack wraps onto the oldest slot
      top_ptr <= next_ptr;
      if (!full) begin
        count <= count + CNT_W'(1);
      end
    end else if (pop_en && !push_en && !empty) begin
      top_ptr <= prev_ptr;
      count   <= count - CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      slots[wr_ptr] <= push_addr;
    end
  end

  assign valid    = !empty;
  assign top_addr = slots[top_ptr];

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  count_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= FULL_COUNT
  ) else $error("RAS count %0d above depth %0d", count, RAS_DEPTH);

endmodule

/* rtl/branch_target_buffer.sv */
module branch_target_buffer
  import fetch_pred_pkg::*;
#(
  parameter int ADDR_W      = 32,
  parameter int BTB_ENTRIES = 16
) (
  input  logic              clk,
  input  logic              rst_n,

  // Lookup side driven by the fetch pc
  input  logic [ADDR_W-1:0] lookup_pc,
  output logic              hit,
  output logic              taken,
  output logic              is_return,
  output logic [ADDR_W-1:0] target,

  // Update side fed by branch resolution
  input  logic              update_en,
  input  logic [ADDR_W-1:0] update_pc,
  input  logic [ADDR_W-1:0] update_target,
  input  logic              update_taken,
  input  logic              update_is_return
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = ADDR_W - ALIGN_BITS - IDX_W;

  // ----------------------------------------
  // Table storage
  // ----------------------------------------

  logic [BTB_ENTRIES-1:0] entry_valid;
  logic [BTB_ENTRIES-1:0] entry_taken;
  logic [BTB_ENTRIES-1:0] entry_is_return;
  logic [TAG_W-1:0]       entry_tag    [BTB_ENTRIES];
  logic [ADDR_W-1:0]      entry_target [BTB_ENTRIES];

  logic [IDX_W-1:0]       lookup_idx;
  logic [TAG_W-1:0]       lookup_tag;
  logic [IDX_W-1:0]       update_idx;
  logic [TAG_W-1:0]       update_tag;

  // Index sits right above the alignment bits, tag is everything above it
  assign lookup_idx = lookup_pc[ALIGN_BITS +: IDX_W];
  assign lookup_tag = lookup_pc[ADDR_W-1 -: TAG_W];
  assign update_idx = update_pc[ALIGN_BITS +: IDX_W];
  assign update_tag = update_pc[ADDR_W-1 -: TAG_W];

  // ----------------------------------------
  // Lookup
  // ----------------------------------------

  // Hit needs a valid entry and a full tag match
  assign hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);

  // Flags only count on a hit
  assign taken     = hit && entry_taken[lookup_idx];
  assign is_return = hit && entry_is_return[lookup_idx];

  // Target is only looked at by the arbiter on a hit
  assign target = entry_target[lookup_idx];

  // ----------------------------------------
  // Update
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
    end else if (update_en) begin
      entry_valid[update_idx] <= 1'b1;
    end
  end

  // Whole entry is rewritten, older contents are lost
  always_ff @(posedge clk) begin
    if (update_en) begin
      entry_tag[update_idx]       <= update_tag;
      entry_target[update_idx]    <= update_target;
      entry_taken[update_idx]     <= update_taken;
      entry_is_return[update_idx] <= update_is_return;
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Resolved branches live at instruction boundaries
  update_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    update_en |-> (update_pc[ALIGN_BITS-1:0] == '0)
  ) else $error("BTB update at unaligned pc %h", update_pc);

endmodule

/* rtl/fetch_pred_pkg.sv */
package fetch_pred_pkg;

  // ----------------------------------------
  // Next PC source
  // ----------------------------------------

  // Rule that produced the next fetch address
  typedef enum logic [1:0] {
    PC_SRC_SEQ      = 2'd0,
    PC_SRC_BTB      = 2'd1,
    PC_SRC_RAS      = 2'd2,
    PC_SRC_REDIRECT = 2'd3
  } pc_src_e;

  // ----------------------------------------
  // Instruction alignment
  // ----------------------------------------

  // Size of one instruction in bytes
  // Sequential fetch steps by this amount
  localparam int INSTR_BYTES = 4;

  // Low pc bits that are always zero
  // BTB index bits start right above these
  localparam int ALIGN_BITS = 2;

endpackage
